// File: logic/cin_link_settings.svh
`ifndef CIN_LINK_SETTINGS_SVH
`define CIN_LINK_SETTINGS_SVH

// Deserializer output width, first bit in time at the MSB
`define CIN_NIBBLE_W 4

// Command word width
`define CIN_WORD_W 32

// Nibbles making up one command word
`define CIN_NIBBLES_PER_WORD 8

// Idle fill and alignment pattern
// Leading nibble A appears nowhere else in the word
`define CIN_TRAIN_WORD 32'hA5C396E1

// Back-to-back training words needed for lock
`define CIN_LOCK_WORDS 4

// Running command counter width
`define CIN_COUNT_W 16

`endif

// File: logic/cin_link_pkg.sv
`default_nettype none

`include "cin_link_settings.svh"

package cin_link_pkg;

    // One deserializer output
    typedef logic [`CIN_NIBBLE_W-1:0] nibble_t;

    // One assembled command or training word
    typedef logic [`CIN_WORD_W-1:0] word_t;

    // Bit offset inside a nibble, 0 to 3
    typedef logic [$clog2(`CIN_NIBBLE_W)-1:0] slip_offset_t;

    // Nibble position inside a word, 0 is the leading nibble
    typedef logic [$clog2(`CIN_NIBBLES_PER_WORD)-1:0] nib_index_t;

    // Commands passed on since reset
    typedef logic [`CIN_COUNT_W-1:0] cmd_count_t;

endpackage

`default_nettype wire

// File: logic/cin_bit_align.sv
`timescale 1ns/10ps
`default_nettype none

`include "cin_link_settings.svh"

module cin_bit_align
    import cin_link_pkg::*;
(
    input  wire          rxclk,
    input  wire          reset,
    input  wire nibble_t nibble_in,
    input  wire          bitslip,
    output nibble_t      aligned_nibble,
    output logic         slipped,
    output slip_offset_t slip_offset
);

    // Bitslip level from the previous cycle
    logic bitslip_prev;
    // Rising edge of bitslip seen in rxclk
    logic slip_edge;
    // Raw nibble from the previous cycle
    nibble_t nibble_prev;
    // Previous raw nibble followed by current one
    // Oldest bit sits at the MSB
    logic [2*`CIN_NIBBLE_W-1:0] nibble_pair;

    // A level held high only slips once
    assign slip_edge = bitslip && !bitslip_prev;

    assign nibble_pair = {nibble_prev, nibble_in};

    // Slip control
    always_ff @(posedge rxclk) begin
        if (reset) begin
            bitslip_prev <= 1'b0;
            slipped      <= 1'b0;
            slip_offset  <= '0;
        end else begin
            bitslip_prev <= bitslip;
            slipped      <= slip_edge;
            // Offset wraps 3 -> 0 by width
            if (slip_edge) begin
                slip_offset <= slip_offset + 1'b1;
            end
        end
    end

    // Realignment window
    // Offset k skips the first k bits of the older nibble
    always_ff @(posedge rxclk) begin
        if (reset) begin
            nibble_prev    <= '0;
            aligned_nibble <= '0;
        end else begin
            nibble_prev    <= nibble_in;
            aligned_nibble <= nibble_pair[2*`CIN_NIBBLE_W-1 - slip_offset -: `CIN_NIBBLE_W];
        end
    end

    // Edge detect must space slips at least two cycles apart
    slip_single_cycle: assert property (
        @(posedge rxclk) disable iff (reset)
        slipped |=> !slipped
    );

endmodule

`default_nettype wire

// File: logic/cin_word_assembler.sv
`timescale 1ns/10ps
`default_nettype none

`include "cin_link_settings.svh"

module cin_word_assembler
    import cin_link_pkg::*;
(
    input  wire          rxclk,
    input  wire          reset,
    input  wire nibble_t aligned_nibble,
    input  wire          slipped,
    output word_t        word_window,
    output logic         window_full
);

    // Count needs to reach the full nibble count
    localparam int FILL_W = $clog2(`CIN_NIBBLES_PER_WORD + 1);

    // Saturating count of nibbles since reset or the last slip
    logic [FILL_W-1:0] fill_count;

    // Last eight aligned nibbles
    // Newest at the LSB end so the word reads MSB first
    always_ff @(posedge rxclk) begin
        word_window <= {word_window[`CIN_WORD_W-`CIN_NIBBLE_W-1:0], aligned_nibble};
    end

    // Fill tracking
    always_ff @(posedge rxclk) begin
        if (reset) begin
            fill_count <= '0;
        end else if (slipped) begin
            // Nibble entering now was cut at the old offset
            fill_count <= '0;
        end else if (fill_count != FILL_W'(`CIN_NIBBLES_PER_WORD)) begin
            fill_count <= fill_count + 1'b1;
        end
    end

    // Whole window belongs to the current alignment
    assign window_full = (fill_count == FILL_W'(`CIN_NIBBLES_PER_WORD));

    // Slip must flush the window before it counts as full again
    full_cleared_on_slip: assert property (
        @(posedge rxclk) disable iff (reset)
        slipped |=> !window_full
    );

endmodule

`default_nettype wire

// File: logic/cin_train_monitor.sv
`timescale 1ns/10ps
`default_nettype none

`include "cin_link_settings.svh"

module cin_train_monitor
    import cin_link_pkg::*;
(
    input  wire          rxclk,
    input  wire          reset,
    input  wire nibble_t aligned_nibble,
    input  wire          slipped,
    output logic         locked,
    output logic         word_boundary
);

    localparam word_t      TRAIN_WORD = `CIN_TRAIN_WORD;
    localparam nib_index_t LAST_INDEX = nib_index_t'(`CIN_NIBBLES_PER_WORD - 1);
    localparam int         GOOD_W     = $clog2(`CIN_LOCK_WORDS + 1);
    // Leading training nibble, restart point of the hunt
    localparam nibble_t    FIRST_NIBBLE = TRAIN_WORD[`CIN_WORD_W-1 -: `CIN_NIBBLE_W];

    // Position of the nibble expected next
    nib_index_t index;
    // Complete training words seen back to back
    logic [GOOD_W-1:0] good_words;
    // Training nibble at the current index
    nibble_t expected;

    // Index 0 picks the top nibble of the pattern
    function automatic nibble_t train_nibble(input nib_index_t idx);
        return TRAIN_WORD[(LAST_INDEX - idx) * `CIN_NIBBLE_W +: `CIN_NIBBLE_W];
    endfunction

    assign expected = train_nibble(index);

    always_ff @(posedge rxclk) begin
        if (reset || slipped) begin
            // Old phase means nothing after a slip
            // Back to hunt
            locked        <= 1'b0;
            word_boundary <= 1'b0;
            index         <= '0;
            good_words    <= '0;
        end else if (locked) begin
            // Phase is fixed now
            // Content no longer checked
            index         <= index + 1'b1;
            word_boundary <= (index == LAST_INDEX);
        end else begin
            word_boundary <= 1'b0;
            if (aligned_nibble == expected) begin
                if (index == LAST_INDEX) begin
                    // One more whole training word
                    index <= '0;
                    if (good_words == GOOD_W'(`CIN_LOCK_WORDS - 1)) begin
                        locked     <= 1'b1;
                        good_words <= '0;
                    end else begin
                        good_words <= good_words + 1'b1;
                    end
                end else begin
                    index <= index + 1'b1;
                end
            end else begin
                good_words <= '0;
                // Mismatched nibble may itself start a new word
                if (aligned_nibble == FIRST_NIBBLE) begin
                    index <= nib_index_t'(1);
                end else begin
                    index <= '0;
                end
            end
        end
    end

    // Boundaries only exist at a locked phase
    boundary_needs_lock: assert property (
        @(posedge rxclk) disable iff (reset)
        word_boundary |-> locked
    );

endmodule

`default_nettype wire

// File: logic/cin_command_gate.sv
`timescale 1ns/10ps
`default_nettype none

`include "cin_link_settings.svh"

module cin_command_gate
    import cin_link_pkg::*;
(
    input  wire        rxclk,
    input  wire        reset,
    input  wire word_t word_window,
    input  wire        window_full,
    input  wire        locked,
    input  wire        word_boundary,
    output logic       cmd_valid,
    output word_t      cmd_data,
    output cmd_count_t cmd_count
);

    // Window holds idle fill
    logic is_training;
    // Window holds a command to pass on
    logic emit;

    assign is_training = (word_window == `CIN_TRAIN_WORD);

    // Boundary at a locked phase with a fully refilled window and no idle fill
    assign emit = locked && word_boundary && window_full && !is_training;

    // Strobe and running count
    always_ff @(posedge rxclk) begin
        if (reset) begin
            cmd_valid <= 1'b0;
            cmd_count <= '0;
        end else begin
            // One cycle only without back-pressure
            cmd_valid <= emit;
            // Wraps at the counter width
            if (emit) begin
                cmd_count <= cmd_count + 1'b1;
            end
        end
    end

    // Command word held until the next one
    always_ff @(posedge rxclk) begin
        if (emit) begin
            cmd_data <= word_window;
        end
    end

    // Strobe comes from a boundary seen while locked
    valid_after_lock: assert property (
        @(posedge rxclk) disable iff (reset)
        cmd_valid |-> $past(locked)
    );

endmodule

`default_nettype wire

// File: logic/cin_link_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cin_link_settings.svh"

module cin_link_top
    import cin_link_pkg::*;
(
    input  wire          rxclk,
    input  wire          reset,
    input  wire nibble_t nibble_in,
    input  wire          bitslip,
    output slip_offset_t slip_offset,
    output logic         locked,
    output logic         cmd_valid,
    output word_t        cmd_data,
    output cmd_count_t   cmd_count
);

    // Realigned stream and slip strobe
    nibble_t aligned_nibble;
    logic    slipped;
    // Assembler results
    word_t   word_window;
    logic    window_full;
    // Word phase pulse from the monitor
    logic    word_boundary;

    // Stage 1, bit realignment
    cin_bit_align cin_bit_align_inst (
        .rxclk          (rxclk),
        .reset          (reset),
        .nibble_in      (nibble_in),
        .bitslip        (bitslip),
        .aligned_nibble (aligned_nibble),
        .slipped        (slipped),
        .slip_offset    (slip_offset)
    );

    // Stage 2, window and hunt side by side on the same stream
    cin_word_assembler cin_word_assembler_inst (
        .rxclk          (rxclk),
        .reset          (reset),
        .aligned_nibble (aligned_nibble),
        .slipped        (slipped),
        .word_window    (word_window),
        .window_full    (window_full)
    );

    cin_train_monitor cin_train_monitor_inst (
        .rxclk          (rxclk),
        .reset          (reset),
        .aligned_nibble (aligned_nibble),
        .slipped        (slipped),
        .locked         (locked),
        .word_boundary  (word_boundary)
    );

    // Stage 3, command strobes
    cin_command_gate cin_command_gate_inst (
        .rxclk          (rxclk),
        .reset          (reset),
        .word_window    (word_window),
        .window_full    (window_full),
        .locked         (locked),
        .word_boundary  (word_boundary),
        .cmd_valid      (cmd_valid),
        .cmd_data       (cmd_data),
        .cmd_count      (cmd_count)
    );

endmodule

`default_nettype wire

// File: bench/cin_link_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cin_link_settings.svh"

module cin_link_tb
    import cin_link_pkg::*;
();

    localparam word_t TRAIN_WORD    = `CIN_TRAIN_WORD;
    localparam int    RESET_CYCLES  = 4;
    localparam int    CMD_WAIT      = 32;
    localparam int    SETTLE        = 16;
    // Words streamed per test including dwells and gaps
    localparam int    T2_WORDS      = 16;
    localparam int    T3_WORDS      = 24;
    localparam int    T4_WORDS      = 32;
    localparam int    T5_WORDS      = 84;
    localparam int    TOTAL_NIBBLES =
        `CIN_NIBBLES_PER_WORD * (T2_WORDS + T3_WORDS + T4_WORDS + T5_WORDS)
        + 4 * (CMD_WAIT + SETTLE) + 2 * (RESET_CYCLES + 1);
    localparam int    WATCHDOG_NS   = (TOTAL_NIBBLES + 200) * 8;

    logic         rxclk;
    logic         reset;
    nibble_t      nibble_in;
    logic         bitslip;
    slip_offset_t slip_offset;
    logic         locked;
    logic         cmd_valid;
    word_t        cmd_data;
    cmd_count_t   cmd_count;

    // Serial bits still to go out, oldest first
    logic        bit_q[$];
    // Words caught on cmd_valid
    word_t       cmd_q[$];
    // Words the current batch should produce
    word_t       exp_q[$];
    logic [31:0] rng_state;
    int          error_count;
    int          checked_count;
    // Commands sent since the last reset
    int          expected_total;

    cin_link_top cin_link_top_inst (
        .rxclk       (rxclk),
        .reset       (reset),
        .nibble_in   (nibble_in),
        .bitslip     (bitslip),
        .slip_offset (slip_offset),
        .locked      (locked),
        .cmd_valid   (cmd_valid),
        .cmd_data    (cmd_data),
        .cmd_count   (cmd_count)
    );

    initial begin
        rxclk = 1'b0;
        forever #4 rxclk = ~rxclk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Random word other than the idle-fill training word
    function automatic word_t random_command();
        word_t w;
        rng_state = xorshift(rng_state);
        w = rng_state;
        if (w == TRAIN_WORD) begin
            w = ~w;
        end
        return w;
    endfunction

    // MSB leaves first
    function automatic void push_word(input word_t w);
        for (int i = `CIN_WORD_W - 1; i >= 0; i--) begin
            bit_q.push_back(w[i]);
        end
    endfunction

    // Serializer model
    // One nibble per edge
    // Link idles with training words whenever the queue runs dry
    always @(posedge rxclk) begin : nibble_driver
        nibble_t nib;
        nib = '0;
        if (bit_q.size() < `CIN_NIBBLE_W) begin
            push_word(TRAIN_WORD);
        end
        for (int i = 0; i < `CIN_NIBBLE_W; i++) begin
            nib = {nib[`CIN_NIBBLE_W-2:0], bit_q.pop_front()};
        end
        nibble_in <= nib;
    end

    // Command catcher sampling mid-cycle
    always @(negedge rxclk) begin
        if (cmd_valid === 1'b1) begin
            cmd_q.push_back(cmd_data);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checked_count++;
        if (got !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t",
                     name, got, expected, $time);
            error_count++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s at %0t", what, $time);
        error_count++;
    endtask

    // Reset for four edges
    // Stream restarts with junk_bits of lead-in
    task automatic apply_reset(input int junk_bits);
        @(posedge rxclk);
        reset <= 1'b1;
        @(negedge rxclk);
        bit_q.delete();
        for (int i = 0; i < junk_bits; i++) begin
            rng_state = xorshift(rng_state);
            bit_q.push_back(rng_state[0]);
        end
        repeat (RESET_CYCLES) @(posedge rxclk);
        reset <= 1'b0;
        expected_total = 0;
        cmd_q.delete();
    endtask

    task automatic pulse_bitslip(input int high_cycles);
        @(posedge rxclk);
        bitslip <= 1'b1;
        repeat (high_cycles) @(posedge rxclk);
        bitslip <= 1'b0;
        repeat (3) @(posedge rxclk);
    endtask

    // Only idle fill on the link meanwhile
    task automatic expect_no_lock(input int cycles);
        logic seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge rxclk);
            if (locked !== 1'b0) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            report_problem($sformatf("locked rose at slip offset %0d", slip_offset));
        end
    endtask

    // Leading training words followed by commands with training runs between
    task automatic send_batch(input int lead, input int cmds,
                              input int min_gap, input int max_gap);
        word_t w;
        int    gap;
        @(posedge rxclk);
        cmd_q.delete();
        exp_q.delete();
        @(negedge rxclk);
        repeat (lead) push_word(TRAIN_WORD);
        for (int i = 0; i < cmds; i++) begin
            w = random_command();
            push_word(w);
            exp_q.push_back(w);
            expected_total++;
            rng_state = xorshift(rng_state);
            gap = min_gap + int'(rng_state % (max_gap - min_gap + 1));
            repeat (gap) push_word(TRAIN_WORD);
        end
        // Wait until the serializer has taken every queued word
        while (bit_q.size() >= `CIN_NIBBLE_W) begin
            @(negedge rxclk);
        end
    endtask

    task automatic collect_commands(input int expected_cmds);
        int cycles;
        cycles = 0;
        while (cmd_q.size() < expected_cmds && cycles < CMD_WAIT) begin
            @(posedge rxclk);
            cycles++;
        end
        if (cmd_q.size() < expected_cmds) begin
            report_problem("timed out waiting for commands");
        end
        // Late extras would show up here
        repeat (SETTLE) @(posedge rxclk);
        if (cmd_q.size() != exp_q.size()) begin
            report_problem($sformatf("expected %0d commands, saw %0d",
                                     exp_q.size(), cmd_q.size()));
        end
        for (int i = 0; i < cmd_q.size() && i < exp_q.size(); i++) begin
            check_value($sformatf("cmd_data[%0d]", i), cmd_q[i], exp_q[i]);
        end
    endtask

    task automatic check_status(input logic exp_locked);
        @(negedge rxclk);
        check_value("locked", locked, exp_locked);
        check_value("cmd_count", cmd_count, expected_total);
    endtask

    task automatic verify_reset_state();
        apply_reset(0);
        @(negedge rxclk);
        check_value("locked", locked, 0);
        check_value("cmd_valid", cmd_valid, 0);
        check_value("slip_offset", slip_offset, 0);
        check_value("cmd_count", cmd_count, 0);
    endtask

    task automatic lock_aligned_stream();
        send_batch(6, 5, 1, 1);
        collect_commands(5);
        check_status(1'b1);
    endtask

    // Word starts two bits into the stream
    // Needs offset 2
    task automatic recover_misaligned_start();
        apply_reset(2);
        expect_no_lock(8 * `CIN_NIBBLES_PER_WORD);
        // Long high level still counts as one slip
        pulse_bitslip(5);
        pulse_bitslip(3);
        @(negedge rxclk);
        check_value("slip_offset", slip_offset, 2);
        send_batch(6, 4, 1, 1);
        collect_commands(4);
        check_status(1'b1);
    endtask

    task automatic relock_after_slip();
        pulse_bitslip(1);
        @(negedge rxclk);
        check_value("locked", locked, 0);
        check_value("slip_offset", slip_offset, 3);
        expect_no_lock(6 * `CIN_NIBBLES_PER_WORD);
        // Offsets 0 and 1 must not lock either
        repeat (2) begin
            pulse_bitslip(1);
            expect_no_lock(6 * `CIN_NIBBLES_PER_WORD);
        end
        pulse_bitslip(1);
        @(negedge rxclk);
        check_value("slip_offset", slip_offset, 2);
        send_batch(6, 3, 1, 1);
        collect_commands(3);
        check_status(1'b1);
    endtask

    task automatic suppress_training_words();
        send_batch(2, 20, 0, 3);
        collect_commands(20);
        check_status(1'b1);
    endtask

    initial begin : main_sequence
        reset          = 1'b1;
        bitslip        = 1'b0;
        nibble_in      = '0;
        rng_state      = 32'h779c;
        error_count    = 0;
        checked_count  = 0;
        expected_total = 0;
        verify_reset_state();
        lock_aligned_stream();
        recover_misaligned_start();
        relock_after_slip();
        suppress_training_words();
        $display("Errors: %0d, checks: %0d", error_count, checked_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Budget covers every streamed nibble plus slack
    initial begin : watchdog
        #(WATCHDOG_NS);
        report_problem("watchdog expired before the tests finished");
        $display("Errors: %0d, checks: %0d", error_count, checked_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/cin_link_pkg.sv
logic/cin_bit_align.sv
logic/cin_word_assembler.sv
logic/cin_train_monitor.sv
logic/cin_command_gate.sv
logic/cin_link_top.sv
bench/cin_link_tb.sv

// File: Bender.yml
package:
  name: cin_link

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cin_link_pkg.sv
      - logic/cin_bit_align.sv
      - logic/cin_word_assembler.sv
      - logic/cin_train_monitor.sv
      - logic/cin_command_gate.sv
      - logic/cin_link_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/cin_link_tb.sv
